// File: build.f
+incdir+verilog
verilog/efi_pkg.sv
verilog/register_file.sv
verilog/efi_memory_handler.sv
verilog/efi_running_sum.sv
verilog/efi_subsystem.sv
testbench/efi_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the EFI subsystem testbench with Verilator from the project root.
cd "$(dirname "$0")" &&
rm -rf obj_dir build.log sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module efi_subsystem_tb \
    -f build.f -o efi_sim > build.log 2>&1 &&
./obj_dir/efi_sim > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -qx "All tests passed" sim.log &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

// File: testbench/efi_subsystem_tb.sv
// Directed tests for the EFI subsystem, checked against a shadow model of the register file.
// Inputs change on the falling clock edge. Host traffic is only issued while busy is low.

`timescale 1ns/1ps
`include "efi_defines.svh"

module efi_subsystem_tb;

    localparam int NUM_TESTS  = 6;
    localparam int RUN_CYCLES = (16 + 4) * 2;
    // Loads and readbacks take two cycles each, with up to 32 of each per test
    localparam int HOST_CYCLES     = 4 * 32;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (2 * RUN_CYCLES + HOST_CYCLES) + 200;

    logic                           clock;
    logic                           arst_n;
    logic                           start;
    logic [`EFI_CHANNEL_WIDTH-1:0]  channel;
    logic [`EFI_REG_ADDR_WIDTH-1:0] arguments_base;
    logic [`EFI_REG_ADDR_WIDTH-1:0] return_base;
    logic [`EFI_LENGTH_WIDTH-1:0]   length;
    efi_pkg::reg_write_t            host_write;
    logic [`EFI_REG_ADDR_WIDTH-1:0] host_read_address;
    logic [`EFI_DATA_WIDTH-1:0]     host_read_data;
    logic                           busy;

    // Expected contents of every register
    logic [`EFI_DATA_WIDTH-1:0] shadow [1 << `EFI_REG_ADDR_WIDTH];

    integer seed;
    int     error_count;
    int     check_count;
    int     test_count;

    efi_subsystem i_dut (
        .clock             (clock),
        .arst_n            (arst_n),
        .start             (start),
        .channel           (channel),
        .arguments_base    (arguments_base),
        .return_base       (return_base),
        .length            (length),
        .host_write        (host_write),
        .host_read_address (host_read_address),
        .host_read_data    (host_read_data),
        .busy              (busy)
    );

    always #10 clock = ~clock;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [`EFI_DATA_WIDTH-1:0] random_word();
        return `EFI_DATA_WIDTH'($random(seed));
    endfunction

    task automatic check_data(input string name, input logic [`EFI_DATA_WIDTH-1:0] got,
                              input logic [`EFI_DATA_WIDTH-1:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic load_register(input logic [`EFI_REG_ADDR_WIDTH-1:0] address,
                                 input logic [`EFI_DATA_WIDTH-1:0] data);
        @(negedge clock);
        host_write.enable  = 1'b1;
        host_write.address = address;
        host_write.data    = data;
        shadow[address]    = data;
        @(negedge clock);
        host_write.enable = 1'b0;
    endtask

    task automatic read_register(input logic [`EFI_REG_ADDR_WIDTH-1:0] address,
                                 output logic [`EFI_DATA_WIDTH-1:0] data);
        @(negedge clock);
        host_read_address = address;
        @(negedge clock);
        data = host_read_data;
    endtask

    task automatic verify_register(input logic [`EFI_REG_ADDR_WIDTH-1:0] address);
        logic [`EFI_DATA_WIDTH-1:0] got;
        read_register(address, got);
        check_data($sformatf("host_read_data at %02h", address), got, shadow[address]);
    endtask

    task automatic verify_bank(input logic [`EFI_CHANNEL_WIDTH-1:0] ch);
        for (int i = 0; i < 16; i++) begin
            verify_register({ch, `EFI_BANK_ADDR_WIDTH'(i)});
        end
    endtask

    // Arguments are gathered first, which matches the hardware as long as each
    // argument register is read before a result lands on it
    task automatic model_run(input logic [`EFI_CHANNEL_WIDTH-1:0] ch,
                             input logic [`EFI_REG_ADDR_WIDTH-1:0] a_base,
                             input logic [`EFI_REG_ADDR_WIDTH-1:0] r_base,
                             input logic [`EFI_LENGTH_WIDTH-1:0] len);
        logic [`EFI_DATA_WIDTH-1:0]     args [16];
        logic [`EFI_DATA_WIDTH-1:0]     sum;
        logic [`EFI_REG_ADDR_WIDTH-1:0] offset;
        offset = {ch, `EFI_BANK_ADDR_WIDTH'(0)};
        for (int i = 0; i < int'(len); i++) begin
            args[i] = shadow[a_base + `EFI_REG_ADDR_WIDTH'(i) + offset];
        end
        sum = '0;
        for (int i = 0; i < int'(len); i++) begin
            sum = sum + args[i];
            shadow[r_base + `EFI_REG_ADDR_WIDTH'(i) + offset] = sum;
        end
    endtask

    // Every caller returns on a falling edge, so the start strobe goes out at once
    task automatic run_efi(input logic [`EFI_CHANNEL_WIDTH-1:0] ch,
                           input logic [`EFI_REG_ADDR_WIDTH-1:0] a_base,
                           input logic [`EFI_REG_ADDR_WIDTH-1:0] r_base,
                           input logic [`EFI_LENGTH_WIDTH-1:0] len);
        int cycles;
        channel        = ch;
        arguments_base = a_base;
        return_base    = r_base;
        length         = len;
        start          = 1'b1;
        @(negedge clock);
        start  = 1'b0;
        cycles = 0;
        while (!busy && cycles < 4) begin
            @(negedge clock);
            cycles++;
        end
        if (!busy) begin
            error_count++;
            $display("Run on channel %0d never raised busy", ch);
        end
        cycles = 0;
        while (busy && cycles < int'(len) + 10) begin
            @(negedge clock);
            cycles++;
        end
        if (busy) begin
            error_count++;
            $display("Run on channel %0d did not finish within %0d cycles", ch, cycles);
        end
        model_run(ch, a_base, r_base, len);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("Test %0d %s finished with %0d errors", test_count, name,
                 error_count - errors_before);
    endtask

    task automatic host_access_roundtrip();
        logic [`EFI_REG_ADDR_WIDTH-1:0] addresses [16];
        int                             errors_before;
        errors_before = error_count;
        for (int i = 0; i < 16; i++) begin
            addresses[i] = `EFI_REG_ADDR_WIDTH'($random(seed));
            load_register(addresses[i], random_word());
        end
        for (int i = 0; i < 16; i++) begin
            verify_register(addresses[i]);
        end
        report_test("host write and read", errors_before);
    endtask

    task automatic single_beat_run();
        logic [`EFI_DATA_WIDTH-1:0] argument;
        logic [`EFI_DATA_WIDTH-1:0] got;
        int                         errors_before;
        errors_before = error_count;
        check_flag("busy after reset", busy, 1'b0);
        argument = random_word();
        load_register(8'h02, argument);
        run_efi(4'd0, 8'h02, 8'h0a, 4'd1);
        // A single beat sum is the argument itself
        read_register(8'h0a, got);
        check_data("host_read_data at 0a", got, argument);
        // Busy must stay low once the run is over
        check_flag("busy after run", busy, 1'b0);
        report_test("single run", errors_before);
    endtask

    task automatic full_length_run();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < 15; i++) begin
            load_register(8'h30 + 8'(i), random_word());
        end
        // Results land just past this bank
        run_efi(4'd3, 8'h00, 8'h10, 4'd15);
        verify_bank(4'd3);
        verify_bank(4'd4);
        report_test("full-length run", errors_before);
    endtask

    task automatic channel_isolation();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < 4; i++) begin
            load_register(8'h10 + 8'(i), random_word());
            load_register(8'h20 + 8'(i), random_word());
        end
        run_efi(4'd1, 8'h00, 8'h08, 4'd4);
        run_efi(4'd2, 8'h00, 8'h08, 4'd4);
        verify_bank(4'd1);
        verify_bank(4'd2);
        report_test("channel offset", errors_before);
    endtask

    task automatic overlapping_regions();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < 6; i++) begin
            load_register(8'h52 + 8'(i), random_word());
        end
        run_efi(4'd5, 8'h02, 8'h02, 4'd6);
        verify_bank(4'd5);
        report_test("overlapping regions", errors_before);
    endtask

    task automatic back_to_back_runs();
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < 5; i++) begin
            load_register(8'h60 + 8'(i), random_word());
        end
        // The second run starts as soon as busy falls and sums the results of the first
        run_efi(4'd6, 8'h00, 8'h08, 4'd5);
        run_efi(4'd6, 8'h08, 8'h00, 4'd5);
        verify_bank(4'd6);
        report_test("back-to-back runs", errors_before);
    endtask

    initial begin
        seed              = 47;
        error_count       = 0;
        check_count       = 0;
        test_count        = 0;
        clock             = 1'b0;
        arst_n            = 1'b0;
        start             = 1'b0;
        channel           = '0;
        arguments_base    = '0;
        return_base       = '0;
        length            = '0;
        host_write        = '0;
        host_read_address = '0;
        for (int i = 0; i < (1 << `EFI_REG_ADDR_WIDTH); i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        host_access_roundtrip();
        single_beat_run();
        full_length_run();
        channel_isolation();
        overlapping_regions();
        back_to_back_runs();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verilog/efi_subsystem.sv
// EFI path top level with a host port on the register file.
// Host writes are only honoured while busy is low; during a run the write port
// belongs to the result writeback.

`timescale 1ns/1ps
`include "efi_defines.svh"

module efi_subsystem (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            start,
    input  logic [`EFI_CHANNEL_WIDTH-1:0]   channel,
    input  logic [`EFI_REG_ADDR_WIDTH-1:0]  arguments_base,
    input  logic [`EFI_REG_ADDR_WIDTH-1:0]  return_base,
    input  logic [`EFI_LENGTH_WIDTH-1:0]    length,
    input  efi_pkg::reg_write_t             host_write,
    input  logic [`EFI_REG_ADDR_WIDTH-1:0]  host_read_address,
    output logic [`EFI_DATA_WIDTH-1:0]      host_read_data,
    output logic                            busy
);

    efi_pkg::efi_beat_t             efi_arguments;
    efi_pkg::efi_beat_t             efi_results;
    efi_pkg::reg_write_t            writeback;
    efi_pkg::reg_write_t            rf_write;
    logic [`EFI_REG_ADDR_WIDTH-1:0] mem_address;
    logic [`EFI_DATA_WIDTH-1:0]     mem_read_data;

    // Write port arbitration
    assign rf_write = busy ? writeback : host_write;

    efi_memory_handler i_handler (
        .clock          (clock),
        .arst_n         (arst_n),
        .start          (start),
        .channel        (channel),
        .arguments_base (arguments_base),
        .return_base    (return_base),
        .length         (length),
        .mem_address    (mem_address),
        .mem_read_data  (mem_read_data),
        .efi_arguments  (efi_arguments),
        .efi_results    (efi_results),
        .writeback      (writeback),
        .busy           (busy)
    );

    efi_running_sum i_efi (
        .clock     (clock),
        .arst_n    (arst_n),
        .arguments (efi_arguments),
        .results   (efi_results)
    );

    register_file i_register_file (
        .clock          (clock),
        .arst_n         (arst_n),
        .write          (rf_write),
        .read_address_a (mem_address),
        .read_data_a    (mem_read_data),
        .read_address_b (host_read_address),
        .read_data_b    (host_read_data)
    );

    // A host write during a run would be silently lost
    a_no_host_write_busy: assert property (@(posedge clock) disable iff (!arst_n)
        host_write.enable |-> !busy);

endmodule

// File: verilog/efi_running_sum.sv
// EFI unit returning the running sum of its argument stream, wrapping at the data width.
// Answers each argument beat exactly one cycle later and cannot stall.

`timescale 1ns/1ps
`include "efi_defines.svh"

module efi_running_sum (
    input  logic               clock,
    input  logic               arst_n,
    input  efi_pkg::efi_beat_t arguments,
    output efi_pkg::efi_beat_t results
);

    logic                       first_beat;
    logic [`EFI_DATA_WIDTH-1:0] sum_next;

    // The result register doubles as the accumulator of the current stream
    assign sum_next = first_beat ? arguments.data : results.data + arguments.data;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            results    <= '0;
            first_beat <= 1'b1;
        end else begin
            results.valid <= arguments.valid;
            if (arguments.valid) begin
                results.data <= sum_next;
                results.dest <= arguments.dest;
                results.last <= arguments.last;
                // A new stream starts after the last beat
                first_beat   <= arguments.last;
            end
        end
    end

    // Within a stream the beat index steps by one, checked against the previous beat
    a_dest_increments: assert property (@(posedge clock) disable iff (!arst_n)
        arguments.valid && !first_beat |-> arguments.dest == results.dest + 1'b1);

endmodule

// File: verilog/efi_memory_handler.sv
// Streams a run of argument registers to the EFI unit and writes the results back.
// Length must be nonzero. Addresses wrap within the whole register file, so a
// base near the end of a bank spills into the next bank.

`timescale 1ns/1ps
`include "efi_defines.svh"

module efi_memory_handler (
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            start,
    input  logic [`EFI_CHANNEL_WIDTH-1:0]   channel,
    input  logic [`EFI_REG_ADDR_WIDTH-1:0]  arguments_base,
    input  logic [`EFI_REG_ADDR_WIDTH-1:0]  return_base,
    input  logic [`EFI_LENGTH_WIDTH-1:0]    length,
    output logic [`EFI_REG_ADDR_WIDTH-1:0]  mem_address,
    input  logic [`EFI_DATA_WIDTH-1:0]      mem_read_data,
    output efi_pkg::efi_beat_t              efi_arguments,
    input  efi_pkg::efi_beat_t              efi_results,
    output efi_pkg::reg_write_t             writeback,
    output logic                            busy
);

    localparam int ADDR_W = `EFI_REG_ADDR_WIDTH;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT
    } state_t;

    state_t                          state;
    logic                            start_q;
    logic [`EFI_CHANNEL_WIDTH-1:0]   channel_q;
    logic [`EFI_REG_ADDR_WIDTH-1:0]  arguments_base_q;
    logic [`EFI_REG_ADDR_WIDTH-1:0]  return_base_q;
    logic [`EFI_LENGTH_WIDTH-1:0]    length_q;
    logic [`EFI_LENGTH_WIDTH-1:0]    index;
    logic [`EFI_REG_ADDR_WIDTH-1:0]  bank_offset;

    // Channel times the bank size
    assign bank_offset = {channel_q, {`EFI_BANK_ADDR_WIDTH{1'b0}}};

    // The register for the current beat index is read combinationally
    assign mem_address = arguments_base_q + ADDR_W'(index) + bank_offset;

    // Run parameters are taken when a start is accepted
    always_ff @(posedge clock) begin
        if (start && !busy) begin
            channel_q        <= channel;
            arguments_base_q <= arguments_base;
            return_base_q    <= return_base;
            length_q         <= length;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state         <= ST_IDLE;
            start_q       <= 1'b0;
            busy          <= 1'b0;
            index         <= '0;
            efi_arguments <= '0;
        end else begin
            start_q             <= start && !busy;
            efi_arguments.valid <= 1'b0;
            efi_arguments.last  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    index <= '0;
                    if (start_q && !busy) begin
                        state <= ST_SEND;
                        busy  <= 1'b1;
                    end else if (busy) begin
                        // Last writeback is in flight this cycle
                        busy <= 1'b0;
                    end
                end
                ST_SEND: begin
                    efi_arguments.valid <= 1'b1;
                    efi_arguments.dest  <= index;
                    efi_arguments.data  <= mem_read_data;
                    if (index == length_q - 1'b1) begin
                        efi_arguments.last <= 1'b1;
                        state              <= ST_WAIT;
                    end else begin
                        index <= index + 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (efi_results.valid && efi_results.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Results may already arrive while arguments are still being sent
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            writeback <= '0;
        end else begin
            writeback.enable <= efi_results.valid;
            if (efi_results.valid) begin
                writeback.address <= return_base_q + ADDR_W'(efi_results.dest) + bank_offset;
                writeback.data    <= efi_results.data;
            end
        end
    end

    a_length_nonzero: assert property (@(posedge clock) disable iff (!arst_n)
        start && !busy |-> length != '0);

    a_no_result_when_idle: assert property (@(posedge clock) disable iff (!arst_n)
        efi_results.valid |-> state != ST_IDLE);

    // Argument beats only go out during a run and never past its length
    a_arguments_in_run: assert property (@(posedge clock) disable iff (!arst_n)
        efi_arguments.valid |-> busy && efi_arguments.dest < length_q);

endmodule

// File: verilog/register_file.sv
// Register file split into channel banks of 16 registers each.
// Reads are combinational, so a read and a write to one address in the same
// cycle return the old value.

`timescale 1ns/1ps
`include "efi_defines.svh"

module register_file (
    input  logic                           clock,
    input  logic                           arst_n,
    input  efi_pkg::reg_write_t            write,
    input  logic [`EFI_REG_ADDR_WIDTH-1:0] read_address_a,
    output logic [`EFI_DATA_WIDTH-1:0]     read_data_a,
    input  logic [`EFI_REG_ADDR_WIDTH-1:0] read_address_b,
    output logic [`EFI_DATA_WIDTH-1:0]     read_data_b
);

    localparam int NUM_REGS = 1 << `EFI_REG_ADDR_WIDTH;

    logic [`EFI_DATA_WIDTH-1:0] registers [NUM_REGS];

    // All registers start from zero so that a run on an unloaded bank is defined
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                registers[i] <= '0;
            end
        end else if (write.enable) begin
            registers[write.address] <= write.data;
        end
    end

    // Port a serves the memory handler, port b the host
    assign read_data_a = registers[read_address_a];
    assign read_data_b = registers[read_address_b];

endmodule

// File: verilog/efi_pkg.sv
// Stream and register write types for the EFI path.
// Streams carry no ready signal, so a receiver must accept every valid beat.

`include "efi_defines.svh"

package efi_pkg;

    // One beat of an argument or result stream
    typedef struct packed {
        logic                          valid;
        logic                          last;
        // Beat index within the stream
        logic [`EFI_LENGTH_WIDTH-1:0]  dest;
        logic [`EFI_DATA_WIDTH-1:0]    data;
    } efi_beat_t;

    // One register file write
    typedef struct packed {
        logic                           enable;
        logic [`EFI_REG_ADDR_WIDTH-1:0] address;
        logic [`EFI_DATA_WIDTH-1:0]     data;
    } reg_write_t;

endpackage

// File: verilog/efi_defines.svh
// Widths shared by the EFI path. The bank and channel widths together must equal
// the register address width, since bank offsets are formed by concatenation.

`ifndef EFI_DEFINES_SVH
`define EFI_DEFINES_SVH

// Register and stream data width, one word
`define EFI_DATA_WIDTH 20

// 256 registers in the whole register file
`define EFI_REG_ADDR_WIDTH 8

// 16 registers per channel bank
`define EFI_BANK_ADDR_WIDTH 4

// 16 channel banks
`define EFI_CHANNEL_WIDTH 4

// Stream length and beat index, so at most 15 beats per run
`define EFI_LENGTH_WIDTH 4

`endif
